//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = exec_units_tb
FILELIST = files.f
LOG      = sim.log
PASS     = Test completed successfully

SOURCES  = $(wildcard source/*.sv) $(wildcard dv/*.sv)
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/exec_trace.txt
# clear | alu: valid tag halt pc npc inst rs1 rs2 opa_sel opb_sel func cond uncond
# mult: valid tag halt func rs1 rs2 | exp alu: valid tag halt value redirect redirect_pc | exp mult: valid tag halt value
0 1 01 0 00001000 00001004 00000033 00000005 00000003 0 0 0 0 0 1 11 0 0 00000007 00000006 1 01 0 00000008 0 00001004 0 00 0 00000000
0 1 02 0 00001000 00001004 00000033 00000003 00000005 0 0 1 0 0 1 12 0 1 80000000 80000000 1 02 0 fffffffe 0 00001004 0 00 0 00000000
0 1 03 0 00001000 00001004 00000033 f0f0f0f0 ff00ff00 0 0 2 0 0 1 13 1 2 ffffffff ffffffff 1 03 0 f000f000 0 00001004 0 00 0 00000000
0 1 04 0 00001000 00001004 00000033 f0f0f0f0 0f0f0000 0 0 3 0 0 1 14 0 3 ffffffff ffffffff 1 04 0 fffff0f0 0 00001004 1 11 0 0000002a
0 1 05 0 00001000 00001004 00000033 ffffffff 12345678 0 0 4 0 0 0 00 0 0 00000000 00000000 1 05 0 edcba987 0 00001004 1 12 0 40000000
0 1 06 0 00001000 00001004 00000033 fffffffe 00000001 0 0 5 0 0 1 15 0 0 7fffffff ffffffff 1 06 0 00000001 0 00001004 1 13 1 ffffffff
0 1 07 0 00001000 00001004 00000033 fffffffe 00000001 0 0 6 0 0 1 16 0 1 fffffffe 00000003 1 07 0 00000000 0 00001004 1 14 0 fffffffe
0 1 08 0 00001000 00001004 00000033 00000001 00000024 0 0 7 0 0 0 00 0 0 00000000 00000000 1 08 0 00000010 0 00001004 0 00 0 00000000
0 1 09 0 00001000 00001004 00400000 80000000 00000000 0 1 9 0 0 0 00 0 0 00000000 00000000 1 09 0 f8000000 0 00001004 1 15 0 80000001
0 1 0a 0 00001000 00001004 00000033 80000000 00000004 0 0 8 0 0 1 17 0 0 00000002 00000003 1 0a 0 08000000 0 00001004 1 16 0 ffffffff
0 1 0b 0 00001000 00001004 12345000 00000000 00000000 3 3 0 0 0 1 18 0 0 00000004 00000005 1 0b 0 12345000 0 00001004 0 00 0 00000000
1 1 1f 0 00001000 00001004 00000033 00000001 00000001 0 0 0 0 0 1 19 0 0 00000006 00000007 0 00 0 00000000 0 00000000 0 00 0 00000000
0 1 0c 0 00001000 00001004 fffff000 00000000 00000000 2 3 0 0 0 0 00 0 0 00000000 00000000 1 0c 0 00000000 0 00001004 0 00 0 00000000
0 1 0d 0 00001000 00001004 fff00000 00000000 00000000 1 1 0 0 0 0 00 0 0 00000000 00000000 1 0d 0 00001003 0 00001004 0 00 0 00000000
0 1 0e 0 00002000 00002004 00000863 00000005 00000006 2 2 0 1 0 0 00 0 0 00000000 00000000 1 0e 0 00002010 0 00002004 0 00 0 00000000
0 1 0f 0 00002000 00002004 00001863 00000005 00000006 2 2 0 1 0 1 1a 0 3 00010000 00010000 1 0f 0 00002010 1 00002010 0 00 0 00000000
0 1 10 0 00002000 00002010 00004863 fffffffb 00000003 2 2 0 1 0 0 00 0 0 00000000 00000000 1 10 0 00002010 0 00002010 0 00 0 00000000
0 1 11 0 00002000 00002010 00005863 fffffffb 00000003 2 2 0 1 0 0 00 0 0 00000000 00000000 1 11 0 00002010 1 00002004 0 00 0 00000000
0 1 12 0 00002000 00002004 00006863 fffffffb 00000003 2 2 0 1 0 0 00 0 0 00000000 00000000 1 12 0 00002010 0 00002004 1 1a 0 00000001
0 1 13 0 00002000 00002010 fe0078e3 fffffffb 00000003 2 2 0 1 0 0 00 0 0 00000000 00000000 1 13 0 00001ff0 1 00001ff0 0 00 0 00000000
0 1 14 0 00002000 00002004 1000006f 00000000 00000000 2 4 0 0 1 0 00 0 0 00000000 00000000 1 14 0 00002100 1 00002100 0 00 0 00000000
0 1 15 1 00002020 00003008 00800067 00003000 00000000 0 1 0 0 1 0 00 0 0 00000000 00000000 1 15 1 00003008 0 00003008 0 00 0 00000000
0 0 00 0 00000000 00000000 00000000 00000000 00000000 0 0 0 0 0 0 00 0 0 00000000 00000000 0 00 0 00000000 0 00000000 0 00 0 00000000

//--- dv/exec_units_assertions.sv
`timescale 1ns/10ps

module exec_units_assertions (
    input logic                   clock,
    input logic                   reset,
    input logic                   clear,
    input exec_pkg::alu_issue_t   alu_issue,
    input exec_pkg::mult_issue_t  mult_issue,
    input exec_pkg::alu_result_t  alu_result,
    input exec_pkg::mult_result_t mult_result
);

    int unsigned cycles   = 0; // skip the first edges where history is unknown
    int unsigned failures = 0;
    logic        flush;

    assign flush = reset | clear;

    always @(posedge clock) cycles <= cycles + 1;

    alu_latency: assert property (@(posedge clock)
        cycles > 1 && !$past(flush) |-> alu_result.valid == $past(alu_issue.valid))
        else begin
            failures++;
            $error("alu result valid does not follow issue by one cycle");
        end

    // any flush inside the four cycles drops the operation
    mult_latency: assert property (@(posedge clock)
        cycles > 5 && !$past(flush, 1) && !$past(flush, 2) && !$past(flush, 3)
        && !$past(flush, 4) |-> mult_result.valid == $past(mult_issue.valid, 4))
        else begin
            failures++;
            $error("mult result valid does not follow issue by four cycles");
        end

    quiet_after_reset: assert property (@(posedge clock)
        cycles > 1 && $past(reset) |-> !alu_result.valid && !mult_result.valid)
        else begin
            failures++;
            $error("result valid set in the cycle after reset");
        end

endmodule

bind exec_units exec_units_assertions assertions_0 (.*);

//--- dv/exec_units_tb.sv
`timescale 1ns/10ps

module exec_units_tb;

    localparam int clock_period = 4;
    localparam int field_count  = 30;
    localparam string trace_path = "dv/exec_trace.txt";

    // one cycle of the trace
    typedef struct packed {
        logic                   clear;
        exec_pkg::alu_issue_t   alu;
        exec_pkg::mult_issue_t  mult;
        exec_pkg::alu_result_t  exp_alu;
        exec_pkg::mult_result_t exp_mult;
    } trace_row_t;

    logic                   clock = 1'b0;
    logic                   reset;
    logic                   clear;
    exec_pkg::alu_issue_t   alu_issue;
    exec_pkg::mult_issue_t  mult_issue;
    exec_pkg::alu_result_t  alu_result;
    exec_pkg::mult_result_t mult_result;

    trace_row_t rows[$];
    logic       loaded = 1'b0;

    exec_units uut (
        .clock       (clock),
        .reset       (reset),
        .clear       (clear),
        .alu_issue   (alu_issue),
        .mult_issue  (mult_issue),
        .alu_result  (alu_result),
        .mult_result (mult_result)
    );

    always #(clock_period / 2) clock = ~clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] actual,
                                   input logic [31:0] expected);
        $display("Fail time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
        abort_run("output mismatch against the trace");
    endtask

    task automatic check_alu_result(input exec_pkg::alu_result_t actual,
                                    input exec_pkg::alu_result_t expected);
        if (actual.valid !== expected.valid) begin
            report_mismatch("alu_result.valid", 32'(actual.valid), 32'(expected.valid));
        end
        if (expected.valid) begin // other fields are don't care on an idle slot
            if (actual.tag !== expected.tag)
                report_mismatch("alu_result.tag", 32'(actual.tag), 32'(expected.tag));
            if (actual.halt !== expected.halt)
                report_mismatch("alu_result.halt", 32'(actual.halt), 32'(expected.halt));
            if (actual.value !== expected.value)
                report_mismatch("alu_result.value", actual.value, expected.value);
            if (actual.redirect !== expected.redirect) begin
                report_mismatch("alu_result.redirect", 32'(actual.redirect),
                                32'(expected.redirect));
            end
            if (actual.redirect_pc !== expected.redirect_pc) begin
                report_mismatch("alu_result.redirect_pc", actual.redirect_pc,
                                expected.redirect_pc);
            end
        end
    endtask

    task automatic check_mult_result(input exec_pkg::mult_result_t actual,
                                     input exec_pkg::mult_result_t expected);
        if (actual.valid !== expected.valid) begin
            report_mismatch("mult_result.valid", 32'(actual.valid), 32'(expected.valid));
        end
        if (expected.valid) begin
            if (actual.tag !== expected.tag)
                report_mismatch("mult_result.tag", 32'(actual.tag), 32'(expected.tag));
            if (actual.halt !== expected.halt)
                report_mismatch("mult_result.halt", 32'(actual.halt), 32'(expected.halt));
            if (actual.value !== expected.value)
                report_mismatch("mult_result.value", actual.value, expected.value);
        end
    endtask

    function automatic trace_row_t fields_to_row(input logic [31:0] f [field_count]);
        trace_row_t row;
        row.clear                = f[0][0];
        row.alu.valid            = f[1][0];
        row.alu.tag              = f[2][4:0];
        row.alu.halt             = f[3][0];
        row.alu.pc               = f[4];
        row.alu.npc              = f[5];
        row.alu.inst             = f[6];
        row.alu.rs1_value        = f[7];
        row.alu.rs2_value        = f[8];
        row.alu.opa_sel          = exec_pkg::opa_sel_t'(f[9][1:0]);
        row.alu.opb_sel          = exec_pkg::opb_sel_t'(f[10][2:0]);
        row.alu.func             = exec_pkg::alu_func_t'(f[11][3:0]);
        row.alu.cond_branch      = f[12][0];
        row.alu.uncond_branch    = f[13][0];
        row.mult.valid           = f[14][0];
        row.mult.tag             = f[15][4:0];
        row.mult.halt            = f[16][0];
        row.mult.func            = exec_pkg::mult_func_t'(f[17][1:0]);
        row.mult.rs1_value       = f[18];
        row.mult.rs2_value       = f[19];
        row.exp_alu.valid        = f[20][0];
        row.exp_alu.tag          = f[21][4:0];
        row.exp_alu.halt         = f[22][0];
        row.exp_alu.value        = f[23];
        row.exp_alu.redirect     = f[24][0];
        row.exp_alu.redirect_pc  = f[25];
        row.exp_mult.valid       = f[26][0];
        row.exp_mult.tag         = f[27][4:0];
        row.exp_mult.halt        = f[28][0];
        row.exp_mult.value       = f[29];
        return row;
    endfunction

    task automatic load_trace();
        int          fd;
        int          got;
        string       line;
        logic [31:0] f [field_count];
        fd = $fopen(trace_path, "r");
        if (fd == 0) abort_run("could not open the trace file dv/exec_trace.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == 8'h23) continue; // blank or # comment
            got = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                f[20], f[21], f[22], f[23], f[24], f[25], f[26], f[27], f[28], f[29]);
            if (got != field_count) abort_run("a trace line does not hold 30 fields");
            rows.push_back(fields_to_row(f));
        end
        $fclose(fd);
    endtask

    // stimulus on falling edges, compare just after the rising edge
    initial begin
        reset      = 1'b1;
        clear      = 1'b0;
        alu_issue  = '0;
        mult_issue = '0;
        load_trace();
        loaded = 1'b1;
        repeat (2) @(posedge clock);
        foreach (rows[i]) begin
            @(negedge clock);
            reset      = 1'b0;
            clear      = rows[i].clear;
            alu_issue  = rows[i].alu;
            mult_issue = rows[i].mult;
            @(posedge clock);
            #1;
            check_alu_result(alu_result, rows[i].exp_alu);
            check_mult_result(mult_result, rows[i].exp_mult);
            if (uut.assertions_0.failures != 0) begin
                abort_run("a bound assertion on exec_units failed");
            end
        end
        $display("Test completed successfully");
        $finish;
    end

    // watchdog sized from the trace length
    initial begin
        wait (loaded);
        #((rows.size() + 20 + 2) * clock_period);
        abort_run("watchdog expired before the trace was finished");
    end

endmodule

//--- files.f
source/exec_pkg.sv
source/operand_select.sv
source/int_alu.sv
source/branch_resolve.sv
source/alu_exec_unit.sv
source/mult_stage.sv
source/mult_exec_unit.sv
source/exec_units.sv
dv/exec_units_assertions.sv
dv/exec_units_tb.sv

//--- source/alu_exec_unit.sv
`timescale 1ns/10ps

module alu_exec_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  clear,
    input  exec_pkg::alu_issue_t  issue,
    output exec_pkg::alu_result_t result
);

    exec_pkg::word_t       opa;
    exec_pkg::word_t       opb;
    exec_pkg::word_t       value;
    logic                  redirect;
    exec_pkg::word_t       redirect_pc;
    exec_pkg::alu_result_t next_result;

    operand_select operand_select_0 (
        .issue (issue),
        .opa   (opa),
        .opb   (opb)
    );

    int_alu int_alu_0 (
        .opa   (opa),
        .opb   (opb),
        .func  (issue.func),
        .value (value)
    );

    branch_resolve branch_resolve_0 (
        .issue       (issue),
        .target      (value),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    always_comb begin
        next_result.valid       = issue.valid;
        next_result.tag         = issue.tag;
        next_result.halt        = issue.halt;
        next_result.value       = value;
        next_result.redirect    = issue.valid & redirect; // idle slot never redirects
        next_result.redirect_pc = redirect_pc;
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            result <= '0;
        end else begin
            result <= next_result;
        end
    end

endmodule

//--- source/branch_resolve.sv
`timescale 1ns/10ps

module branch_resolve (
    input  exec_pkg::alu_issue_t issue,
    input  exec_pkg::word_t      target,      // alu sum, the taken destination
    output logic                 redirect,
    output exec_pkg::word_t      redirect_pc
);

    logic [2:0]      funct3;
    logic            cond_true;
    logic            taken;
    logic            is_branch;
    exec_pkg::word_t rs1;
    exec_pkg::word_t rs2;
    exec_pkg::word_t fall_through;

    assign funct3       = issue.inst[14:12];
    assign rs1          = issue.rs1_value;
    assign rs2          = issue.rs2_value;
    assign fall_through = issue.pc + 32'd4;

    always_comb begin
        case (funct3)
            3'd0:    cond_true = (rs1 == rs2);                   // beq
            3'd1:    cond_true = (rs1 != rs2);                   // bne
            3'd4:    cond_true = ($signed(rs1) < $signed(rs2));  // blt
            3'd5:    cond_true = ($signed(rs1) >= $signed(rs2)); // bge
            3'd6:    cond_true = (rs1 < rs2);                    // bltu
            3'd7:    cond_true = (rs1 >= rs2);                   // bgeu
            default: cond_true = 1'b0;
        endcase
    end

    assign taken     = issue.uncond_branch | (issue.cond_branch & cond_true);
    assign is_branch = issue.uncond_branch | issue.cond_branch;

    // actual next pc of this instruction
    assign redirect_pc = taken ? target : fall_through;

    // wrong prediction, whether direction or target
    assign redirect = is_branch & (issue.npc != redirect_pc);

endmodule

//--- source/exec_pkg.sv
package exec_pkg;

    localparam int xlen        = 32;
    localparam int tag_bits    = 5;
    localparam int mult_stages = 4;
    localparam int mult_shift  = 64 / mult_stages; // multiplier bits eaten per stage

    typedef logic [tag_bits-1:0] tag_t;  // reorder buffer slot
    typedef logic [xlen-1:0]     word_t;
    typedef logic [63:0]         dword_t; // full-width product and operands

    typedef enum logic [3:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        slt,
        sltu,
        sll,
        srl,
        sra
    } alu_func_t;

    typedef enum logic [1:0] {
        mul,
        mulh,
        mulhsu,
        mulhu
    } mult_func_t;

    typedef enum logic [1:0] {rs1, npc, pc, zero} opa_sel_t;

    typedef enum logic [2:0] {rs2, i_imm, b_imm, u_imm, j_imm} opb_sel_t;

    typedef struct packed {
        logic      valid;
        tag_t      tag;
        logic      halt;
        word_t     pc;
        word_t     npc;           // predicted next pc
        word_t     inst;
        word_t     rs1_value;
        word_t     rs2_value;
        opa_sel_t  opa_sel;
        opb_sel_t  opb_sel;
        alu_func_t func;
        logic      cond_branch;
        logic      uncond_branch; // jal / jalr
    } alu_issue_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        logic  halt;
        word_t value;
        logic  redirect;     // front end must restart at redirect_pc
        word_t redirect_pc;
    } alu_result_t;

    typedef struct packed {
        logic       valid;
        tag_t       tag;
        logic       halt;
        mult_func_t func;
        word_t      rs1_value;
        word_t      rs2_value;
    } mult_issue_t;

    // rides alongside the partial sums
    typedef struct packed {
        logic valid;
        tag_t tag;
        logic halt;
        logic high_half; // take upper 32 bits of the product
    } mult_payload_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        logic  halt;
        word_t value;
    } mult_result_t;

endpackage

//--- source/exec_units.sv
`timescale 1ns/10ps

module exec_units (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   clear,
    input  exec_pkg::alu_issue_t   alu_issue,
    input  exec_pkg::mult_issue_t  mult_issue,
    output exec_pkg::alu_result_t  alu_result,
    output exec_pkg::mult_result_t mult_result
);

    alu_exec_unit alu_exec_unit_0 (
        .clock  (clock),
        .reset  (reset),
        .clear  (clear),
        .issue  (alu_issue),
        .result (alu_result)  // one cycle after issue
    );

    mult_exec_unit mult_exec_unit_0 (
        .clock  (clock),
        .reset  (reset),
        .clear  (clear),
        .issue  (mult_issue),
        .result (mult_result) // mult_stages cycles after issue
    );

endmodule

//--- source/int_alu.sv
`timescale 1ns/10ps

module int_alu (
    input  exec_pkg::word_t     opa,
    input  exec_pkg::word_t     opb,
    input  exec_pkg::alu_func_t func,
    output exec_pkg::word_t     value
);

    logic [4:0] shamt;

    assign shamt = opb[4:0]; // only low 5 bits count for rv32 shifts

    always_comb begin
        case (func)
            exec_pkg::add:    value = opa + opb;
            exec_pkg::sub:    value = opa - opb;
            exec_pkg::and_op: value = opa & opb;
            exec_pkg::or_op:  value = opa | opb;
            exec_pkg::xor_op: value = opa ^ opb;
            exec_pkg::slt: begin
                value = exec_pkg::word_t'($signed(opa) < $signed(opb));
            end
            exec_pkg::sltu:   value = exec_pkg::word_t'(opa < opb);
            exec_pkg::sll:    value = opa << shamt;
            exec_pkg::srl:    value = opa >> shamt;
            exec_pkg::sra:    value = $signed(opa) >>> shamt; // keeps sign bit
            default:          value = '0;
        endcase
    end

endmodule

//--- source/mult_exec_unit.sv
`timescale 1ns/10ps

module mult_exec_unit (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   clear,
    input  exec_pkg::mult_issue_t  issue,
    output exec_pkg::mult_result_t result
);

    // index 0 feeds stage 0, index mult_stages is the last stage output
    exec_pkg::dword_t        sums     [exec_pkg::mult_stages+1];
    exec_pkg::dword_t        mcands   [exec_pkg::mult_stages+1];
    exec_pkg::dword_t        mpliers  [exec_pkg::mult_stages+1];
    exec_pkg::mult_payload_t payloads [exec_pkg::mult_stages+1];
    exec_pkg::mult_payload_t last;
    logic                    rs1_signed;
    logic                    rs2_signed;

    assign rs1_signed = (issue.func != exec_pkg::mulhu);
    assign rs2_signed = (issue.func == exec_pkg::mul) || (issue.func == exec_pkg::mulh);

    // extend to 64 bits so one unsigned multiply covers every variant
    assign mcands[0]  = {{32{rs1_signed & issue.rs1_value[31]}}, issue.rs1_value};
    assign mpliers[0] = {{32{rs2_signed & issue.rs2_value[31]}}, issue.rs2_value};
    assign sums[0]    = '0;

    always_comb begin
        payloads[0].valid     = issue.valid;
        payloads[0].tag       = issue.tag;
        payloads[0].halt      = issue.halt;
        payloads[0].high_half = (issue.func != exec_pkg::mul);
    end

    for (genvar i = 0; i < exec_pkg::mult_stages; i++) begin : g_stage
        mult_stage mult_stage_i (
            .clock       (clock),
            .reset       (reset),
            .clear       (clear),
            .prev_sum    (sums[i]),
            .mcand       (mcands[i]),
            .mplier      (mpliers[i]),
            .payload_in  (payloads[i]),
            .sum         (sums[i+1]),
            .next_mcand  (mcands[i+1]),
            .next_mplier (mpliers[i+1]),
            .payload_out (payloads[i+1])
        );
    end

    assign last = payloads[exec_pkg::mult_stages];

    always_comb begin
        result.valid = last.valid;
        result.tag   = last.tag;
        result.halt  = last.halt;
        result.value = last.high_half ? sums[exec_pkg::mult_stages][63:32]
                                      : sums[exec_pkg::mult_stages][31:0];
    end

endmodule

//--- source/mult_stage.sv
`timescale 1ns/10ps

module mult_stage (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    clear,
    input  exec_pkg::dword_t        prev_sum,
    input  exec_pkg::dword_t        mcand,
    input  exec_pkg::dword_t        mplier,
    input  exec_pkg::mult_payload_t payload_in,
    output exec_pkg::dword_t        sum,
    output exec_pkg::dword_t        next_mcand,
    output exec_pkg::dword_t        next_mplier,
    output exec_pkg::mult_payload_t payload_out
);

    exec_pkg::dword_t partial_product;
    exec_pkg::dword_t mplier_slice;

    // low slice of the multiplier, zero extended to full width
    assign mplier_slice    = exec_pkg::dword_t'(mplier[exec_pkg::mult_shift-1:0]);
    assign partial_product = mcand * mplier_slice; // upper bits beyond 64 dropped

    // datapath
    always_ff @(posedge clock) begin
        sum         <= prev_sum + partial_product;
        next_mcand  <= mcand << exec_pkg::mult_shift;
        next_mplier <= mplier >> exec_pkg::mult_shift;
    end

    // flush kills whatever is in this stage
    always_ff @(posedge clock) begin
        if (reset || clear) begin
            payload_out <= '0;
        end else begin
            payload_out <= payload_in;
        end
    end

endmodule

//--- source/operand_select.sv
`timescale 1ns/10ps

module operand_select (
    input  exec_pkg::alu_issue_t issue,
    output exec_pkg::word_t      opa,
    output exec_pkg::word_t      opb
);

    exec_pkg::word_t inst;

    assign inst = issue.inst;

    // operand a mux
    always_comb begin
        case (issue.opa_sel)
            exec_pkg::rs1:  opa = issue.rs1_value;
            exec_pkg::npc:  opa = issue.npc;
            exec_pkg::pc:   opa = issue.pc;
            exec_pkg::zero: opa = '0;
            default:        opa = '0;
        endcase
    end

    // operand b mux, immediates sign extended from inst[31]
    always_comb begin
        case (issue.opb_sel)
            exec_pkg::rs2: opb = issue.rs2_value;
            exec_pkg::i_imm: begin
                opb = {{20{inst[31]}}, inst[31:20]};
            end
            exec_pkg::b_imm: begin
                opb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            exec_pkg::u_imm: begin
                opb = {inst[31:12], 12'b0}; // lui / auipc
            end
            exec_pkg::j_imm: begin
                opb = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: opb = '0; // unused encodings
        endcase
    end

endmodule
